// File: Bender.yml
package:
  name: soc_periph_lite

sources:
  - logic/soc_periph_pkg.sv
  - logic/apb_if.sv
  - logic/periph_bus_demux.sv
  - logic/gpio_regs.sv
  - logic/timer_unit.sv
  - logic/wdt_ctrl.sv
  - logic/soc_periph_lite.sv
  - target: simulation
    files:
      - verif/soc_periph_lite_sva.sv
      - verif/tb_soc_periph_lite.sv

// File: logic/apb_if.sv
/*
 * apb bus between the demux and the peripherals
 */
`timescale 1ns/1ns

interface apb_if;

    logic [soc_periph_pkg::APB_ADDR_WIDTH-1:0] paddr;
    logic                                      psel;
    logic                                      penable;
    logic                                      pwrite;
    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] pwdata;
    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] prdata;
    logic                                      pready;
    logic                                      pslverr;

    // requester side
    modport master (
        output paddr, psel, penable, pwrite, pwdata,
        input  prdata, pready, pslverr
    );

    // completer side
    modport slave (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pready, pslverr
    );

endinterface

// File: logic/gpio_regs.sv
/*
 * gpio block
 * direction and output registers, two-flop input synchroniser and
 * sticky rising-edge interrupt status, cleared by a read
 */
`timescale 1ns/1ns

module gpio_regs (
    input  logic                             clk_i,
    input  logic                             arst_n_i,
    apb_if.slave                             bus,
    input  logic [soc_periph_pkg::NGPIO-1:0] gpio_in_i,
    output logic [soc_periph_pkg::NGPIO-1:0] gpio_out_o,
    output logic [soc_periph_pkg::NGPIO-1:0] gpio_dir_o,
    output logic                             gpio_irq_o
);

    logic [soc_periph_pkg::NGPIO-1:0]          sync1_q, sync2_q, prev_q;
    logic [soc_periph_pkg::NGPIO-1:0]          irq_en_q, status_q;
    logic [soc_periph_pkg::WIN_LSB-1:0]        offset;
    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] rdata;
    logic                                      access, err, wr, status_rd;

    assign access    = bus.psel && bus.penable;
    assign offset    = bus.paddr[soc_periph_pkg::WIN_LSB-1:0];
    assign wr        = access && bus.pwrite && !err;
    assign status_rd = access && !bus.pwrite && (offset == soc_periph_pkg::GPIO_IRQ_STATUS);

    // register read mux, IN and IRQ_STATUS are read-only
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (offset)
            soc_periph_pkg::GPIO_DIR:    rdata = gpio_dir_o;
            soc_periph_pkg::GPIO_OUT:    rdata = gpio_out_o;
            soc_periph_pkg::GPIO_IRQ_EN: rdata = irq_en_q;
            soc_periph_pkg::GPIO_IN: begin
                rdata = sync2_q;
                err   = bus.pwrite;
            end
            soc_periph_pkg::GPIO_IRQ_STATUS: begin
                rdata = status_q;
                err   = bus.pwrite;
            end
            default: err = 1'b1;
        endcase
    end

    assign bus.prdata  = rdata;
    assign bus.pready  = access;
    assign bus.pslverr = access && err;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            gpio_dir_o <= '0;
            gpio_out_o <= '0;
            irq_en_q   <= '0;
            sync1_q    <= '0;
            sync2_q    <= '0;
            prev_q     <= '0;
            status_q   <= '0;
        end else begin
            if (wr && offset == soc_periph_pkg::GPIO_DIR) gpio_dir_o <= bus.pwdata;
            if (wr && offset == soc_periph_pkg::GPIO_OUT) gpio_out_o <= bus.pwdata;
            if (wr && offset == soc_periph_pkg::GPIO_IRQ_EN) irq_en_q <= bus.pwdata;
            sync1_q <= gpio_in_i;
            sync2_q <= sync1_q;
            prev_q  <= sync2_q;
            // an edge arriving during the clearing read is kept
            status_q <= (status_rd ? '0 : status_q) | (sync2_q & ~prev_q & irq_en_q);
        end
    end

    assign gpio_irq_o = |status_q;

endmodule

// File: logic/periph_bus_demux.sv
/*
 * peripheral bus demultiplexer
 * decodes paddr[15:12], steers psel to one slave and muxes the response
 * back, unmapped windows get an error response
 */
`timescale 1ns/1ns

module periph_bus_demux (
    apb_if.slave  up_bus,
    apb_if.master gpio_bus,
    apb_if.master timer_bus,
    apb_if.master wdt_bus
);

    soc_periph_pkg::periph_sel_e     sel;
    logic [soc_periph_pkg::WIN_WIDTH-1:0] win;

    assign win = up_bus.paddr[soc_periph_pkg::WIN_LSB +: soc_periph_pkg::WIN_WIDTH];

    always_comb begin
        case (win)
            soc_periph_pkg::WIN_GPIO:  sel = soc_periph_pkg::SEL_GPIO;
            soc_periph_pkg::WIN_TIMER: sel = soc_periph_pkg::SEL_TIMER;
            soc_periph_pkg::WIN_WDT:   sel = soc_periph_pkg::SEL_WDT;
            default:                   sel = soc_periph_pkg::SEL_NONE;
        endcase
    end

    ////////////////////
    // request fan-out
    ////////////////////
    assign gpio_bus.paddr   = up_bus.paddr;
    assign gpio_bus.penable = up_bus.penable;
    assign gpio_bus.pwrite  = up_bus.pwrite;
    assign gpio_bus.pwdata  = up_bus.pwdata;
    assign gpio_bus.psel    = up_bus.psel && (sel == soc_periph_pkg::SEL_GPIO);

    assign timer_bus.paddr   = up_bus.paddr;
    assign timer_bus.penable = up_bus.penable;
    assign timer_bus.pwrite  = up_bus.pwrite;
    assign timer_bus.pwdata  = up_bus.pwdata;
    assign timer_bus.psel    = up_bus.psel && (sel == soc_periph_pkg::SEL_TIMER);

    assign wdt_bus.paddr   = up_bus.paddr;
    assign wdt_bus.penable = up_bus.penable;
    assign wdt_bus.pwrite  = up_bus.pwrite;
    assign wdt_bus.pwdata  = up_bus.pwdata;
    assign wdt_bus.psel    = up_bus.psel && (sel == soc_periph_pkg::SEL_WDT);

    ////////////////////
    // response mux
    ////////////////////
    always_comb begin
        case (sel)
            soc_periph_pkg::SEL_GPIO: begin
                up_bus.prdata  = gpio_bus.prdata;
                up_bus.pready  = gpio_bus.pready;
                up_bus.pslverr = gpio_bus.pslverr;
            end
            soc_periph_pkg::SEL_TIMER: begin
                up_bus.prdata  = timer_bus.prdata;
                up_bus.pready  = timer_bus.pready;
                up_bus.pslverr = timer_bus.pslverr;
            end
            soc_periph_pkg::SEL_WDT: begin
                up_bus.prdata  = wdt_bus.prdata;
                up_bus.pready  = wdt_bus.pready;
                up_bus.pslverr = wdt_bus.pslverr;
            end
            default: begin
                // nothing mapped here, complete the access with an error
                up_bus.prdata  = '0;
                up_bus.pready  = up_bus.psel && up_bus.penable;
                up_bus.pslverr = up_bus.psel && up_bus.penable;
            end
        endcase
    end

endmodule

// File: logic/soc_periph_lite.sv
/*
 * soc_periph_lite top level
 * apb slave port, peripheral demux, gpio, timer and watchdog,
 * plus the fabric controller event vector
 */
`timescale 1ns/1ns

module soc_periph_lite (
    input  logic                                      clk_i,
    input  logic                                      arst_n_i,

    // apb slave port
    input  logic [soc_periph_pkg::APB_ADDR_WIDTH-1:0] paddr_i,
    input  logic                                      psel_i,
    input  logic                                      penable_i,
    input  logic                                      pwrite_i,
    input  logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] pwdata_i,
    output logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] prdata_o,
    output logic                                      pready_o,
    output logic                                      pslverr_o,

    // gpio pins
    input  logic [soc_periph_pkg::NGPIO-1:0]          gpio_in_i,
    output logic [soc_periph_pkg::NGPIO-1:0]          gpio_out_o,
    output logic [soc_periph_pkg::NGPIO-1:0]          gpio_dir_o,

    // events
    input  logic                                      dma_pe_evt_i,
    input  logic                                      dma_pe_irq_i,
    input  logic                                      pf_evt_i,
    output logic [soc_periph_pkg::FC_EVENT_WIDTH-1:0] fc_events_o,

    output logic                                      wdt_reset_o
);

    apb_if up_bus ();
    apb_if gpio_bus ();
    apb_if timer_bus ();
    apb_if wdt_bus ();

    logic gpio_evt;
    logic timer_evt;

    assign up_bus.paddr   = paddr_i;
    assign up_bus.psel    = psel_i;
    assign up_bus.penable = penable_i;
    assign up_bus.pwrite  = pwrite_i;
    assign up_bus.pwdata  = pwdata_i;
    assign prdata_o       = up_bus.prdata;
    assign pready_o       = up_bus.pready;
    assign pslverr_o      = up_bus.pslverr;

    ////////////////////
    // peripherals
    ////////////////////
    periph_bus_demux i_periph_bus (
        .up_bus    ( up_bus    ),
        .gpio_bus  ( gpio_bus  ),
        .timer_bus ( timer_bus ),
        .wdt_bus   ( wdt_bus   )
    );

    gpio_regs i_gpio (
        .clk_i      ( clk_i      ),
        .arst_n_i   ( arst_n_i   ),
        .bus        ( gpio_bus   ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .gpio_dir_o ( gpio_dir_o ),
        .gpio_irq_o ( gpio_evt   )
    );

    timer_unit i_timer (
        .clk_i       ( clk_i     ),
        .arst_n_i    ( arst_n_i  ),
        .bus         ( timer_bus ),
        .timer_irq_o ( timer_evt )
    );

    wdt_ctrl i_wdt (
        .clk_i       ( clk_i       ),
        .arst_n_i    ( arst_n_i    ),
        .bus         ( wdt_bus     ),
        .wdt_reset_o ( wdt_reset_o )
    );

    ////////////////////
    // event vector
    ////////////////////
    // non-ibex layout, every other bit stays zero
    always_comb begin
        fc_events_o                              = '0;
        fc_events_o[soc_periph_pkg::EVT_DMA_PE]  = dma_pe_evt_i;
        fc_events_o[soc_periph_pkg::EVT_DMA_IRQ] = dma_pe_irq_i;
        fc_events_o[soc_periph_pkg::EVT_TIMER]   = timer_evt;
        fc_events_o[soc_periph_pkg::EVT_PF]      = pf_evt_i;
        fc_events_o[soc_periph_pkg::EVT_GPIO]    = gpio_evt;
    end

endmodule

// File: logic/soc_periph_pkg.sv
/*
 * soc peripheral subsystem package
 * bus widths, address map, register offsets, event positions and enums
 */
package soc_periph_pkg;

    // widths
    localparam int APB_ADDR_WIDTH = 32;
    localparam int APB_DATA_WIDTH = 32;
    localparam int NGPIO          = 32;
    localparam int FC_EVENT_WIDTH = 32;

    // window field sits at paddr[15:12]
    localparam int WIN_LSB   = 12;
    localparam int WIN_WIDTH = 4;

    localparam logic [WIN_WIDTH-1:0] WIN_GPIO  = 4'd1;
    localparam logic [WIN_WIDTH-1:0] WIN_TIMER = 4'd2;
    localparam logic [WIN_WIDTH-1:0] WIN_WDT   = 4'd3;

    // gpio offsets
    localparam logic [WIN_LSB-1:0] GPIO_DIR        = 12'h000;
    localparam logic [WIN_LSB-1:0] GPIO_OUT        = 12'h004;
    localparam logic [WIN_LSB-1:0] GPIO_IN         = 12'h008;
    localparam logic [WIN_LSB-1:0] GPIO_IRQ_EN     = 12'h00C;
    localparam logic [WIN_LSB-1:0] GPIO_IRQ_STATUS = 12'h010;

    // timer offsets
    localparam logic [WIN_LSB-1:0] TIMER_CFG = 12'h000;
    localparam logic [WIN_LSB-1:0] TIMER_CNT = 12'h004;
    localparam logic [WIN_LSB-1:0] TIMER_CMP = 12'h008;

    // watchdog offsets and constants
    localparam logic [WIN_LSB-1:0] WDT_CTRL   = 12'h000;
    localparam logic [WIN_LSB-1:0] WDT_LOAD   = 12'h004;
    localparam logic [WIN_LSB-1:0] WDT_KICK   = 12'h008;
    localparam logic [WIN_LSB-1:0] WDT_STATUS = 12'h00C;

    localparam logic [APB_DATA_WIDTH-1:0] WDT_KICK_KEY = 32'h5A5A_5A5A;
    localparam int WDT_RST_CYCLES = 16;

    // fabric controller event bits
    localparam int EVT_DMA_PE  = 8;
    localparam int EVT_DMA_IRQ = 9;
    localparam int EVT_TIMER   = 10;
    localparam int EVT_PF      = 12;
    localparam int EVT_GPIO    = 15;

    typedef enum logic [1:0] {
        SEL_GPIO  = 2'd0,
        SEL_TIMER = 2'd1,
        SEL_WDT   = 2'd2,
        SEL_NONE  = 2'd3
    } periph_sel_e;

    typedef enum logic [1:0] {
        WDT_OFF  = 2'd0,
        WDT_RUN  = 2'd1,
        WDT_BITE = 2'd2
    } wdt_state_e;

endpackage

// File: logic/timer_unit.sv
/*
 * compare timer
 * free-running counter with a one-cycle match pulse and optional
 * clear-on-match
 */
`timescale 1ns/1ns

module timer_unit (
    input  logic clk_i,
    input  logic arst_n_i,
    apb_if.slave bus,
    output logic timer_irq_o
);

    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] cnt_q, cmp_q, rdata;
    logic [soc_periph_pkg::WIN_LSB-1:0]        offset;
    // cfg bit 0 enables counting, bit 1 wraps the count after a match
    logic [1:0]                                cfg_q;
    logic                                      access, err, wr, match;

    assign access = bus.psel && bus.penable;
    assign offset = bus.paddr[soc_periph_pkg::WIN_LSB-1:0];
    assign wr     = access && bus.pwrite && !err;

    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (offset)
            soc_periph_pkg::TIMER_CFG: rdata[1:0] = cfg_q;
            soc_periph_pkg::TIMER_CNT: rdata = cnt_q;
            soc_periph_pkg::TIMER_CMP: rdata = cmp_q;
            default:                   err = 1'b1;
        endcase
    end

    assign bus.prdata  = rdata;
    assign bus.pready  = access;
    assign bus.pslverr = access && err;

    ////////////////////
    // counter
    ////////////////////
    assign match = cfg_q[0] && (cnt_q == cmp_q);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_q <= '0;
            cnt_q <= '0;
            cmp_q <= '1;
        end else begin
            if (wr && offset == soc_periph_pkg::TIMER_CFG) begin
                cfg_q <= bus.pwdata[1:0];
            end
            if (wr && offset == soc_periph_pkg::TIMER_CMP) begin
                cmp_q <= bus.pwdata;
            end
            // a bus preset wins over counting
            if (wr && offset == soc_periph_pkg::TIMER_CNT) begin
                cnt_q <= bus.pwdata;
            end else if (match && cfg_q[1]) begin
                cnt_q <= '0;
            end else if (cfg_q[0]) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign timer_irq_o = match;

endmodule

// File: logic/wdt_ctrl.sv
/*
 * watchdog
 * off/run/bite FSM with a key-checked kick, one down-counter times
 * both the countdown and the reset pulse
 */
`timescale 1ns/1ns

module wdt_ctrl (
    input  logic clk_i,
    input  logic arst_n_i,
    apb_if.slave bus,
    output logic wdt_reset_o
);

    soc_periph_pkg::wdt_state_e                state_q;
    logic [soc_periph_pkg::APB_DATA_WIDTH-1:0] load_q, cnt_q, rdata;
    logic [soc_periph_pkg::WIN_LSB-1:0]        offset;
    logic                                      en_q, access, err, wr;
    logic                                      ctrl_wr, kick_ok;

    assign access  = bus.psel && bus.penable;
    assign offset  = bus.paddr[soc_periph_pkg::WIN_LSB-1:0];
    assign wr      = access && bus.pwrite && !err;
    assign ctrl_wr = wr && (offset == soc_periph_pkg::WDT_CTRL);
    assign kick_ok = wr && (offset == soc_periph_pkg::WDT_KICK)
                     && (bus.pwdata == soc_periph_pkg::WDT_KICK_KEY);

    // KICK reads back zero, STATUS is read-only
    always_comb begin
        rdata = '0;
        err   = 1'b0;
        case (offset)
            soc_periph_pkg::WDT_CTRL: rdata[0] = en_q;
            soc_periph_pkg::WDT_LOAD: rdata = load_q;
            soc_periph_pkg::WDT_KICK: rdata = '0;
            soc_periph_pkg::WDT_STATUS: begin
                rdata[1:0] = state_q;
                rdata[2]   = en_q;
                err        = bus.pwrite;
            end
            default: err = 1'b1;
        endcase
    end

    assign bus.prdata  = rdata;
    assign bus.pready  = access;
    assign bus.pslverr = access && err;

    ////////////////////
    // fsm
    ////////////////////
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= soc_periph_pkg::WDT_OFF;
            en_q    <= 1'b0;
            load_q  <= '0;
            cnt_q   <= '0;
        end else begin
            if (wr && offset == soc_periph_pkg::WDT_LOAD) load_q <= bus.pwdata;
            case (state_q)
                soc_periph_pkg::WDT_OFF: begin
                    if (ctrl_wr && bus.pwdata[0]) begin
                        state_q <= soc_periph_pkg::WDT_RUN;
                        en_q    <= 1'b1;
                        cnt_q   <= load_q;
                    end
                end
                soc_periph_pkg::WDT_RUN: begin
                    if (ctrl_wr && !bus.pwdata[0]) begin
                        state_q <= soc_periph_pkg::WDT_OFF;
                        en_q    <= 1'b0;
                    end else if (kick_ok) begin
                        cnt_q <= load_q;
                    end else if (cnt_q == '0) begin
                        // counter is reused for the pulse length
                        state_q <= soc_periph_pkg::WDT_BITE;
                        cnt_q   <= 32'(soc_periph_pkg::WDT_RST_CYCLES - 1);
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: begin
                    if (cnt_q == '0) begin
                        state_q <= soc_periph_pkg::WDT_OFF;
                        en_q    <= 1'b0;
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
            endcase
        end
    end

    assign wdt_reset_o = (state_q == soc_periph_pkg::WDT_BITE);

endmodule

// File: soc_periph_lite.f
logic/soc_periph_pkg.sv
logic/apb_if.sv
logic/periph_bus_demux.sv
logic/gpio_regs.sv
logic/timer_unit.sv
logic/wdt_ctrl.sv
logic/soc_periph_lite.sv
verif/soc_periph_lite_sva.sv
verif/tb_soc_periph_lite.sv

// File: verif/soc_periph_lite_sva.sv
/*
 * APB protocol and watchdog pulse checks
 * bound to the soc_periph_lite top level
 */
`timescale 1ns/1ns

module soc_periph_lite_sva (
    input logic clk_i,
    input logic arst_n_i,
    input logic psel_i,
    input logic penable_i,
    input logic pready_i,
    input logic pslverr_i,
    input logic wdt_reset_i
);

    // cycles the current reset pulse has been high so far
    logic [7:0] bite_len_q;

    // number of assertion failures seen so far
    int unsigned fail_cnt = 0;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bite_len_q <= '0;
        end else if (wdt_reset_i) begin
            bite_len_q <= bite_len_q + 1'b1;
        end else begin
            bite_len_q <= '0;
        end
    end

    a_err_with_ready: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pslverr_i |-> pready_i)
        else begin
            $error("pslverr without pready");
            fail_cnt++;
        end

    // access cycle only straight after a setup cycle
    a_enable_after_setup: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        penable_i |-> psel_i && $past(psel_i && !penable_i))
        else begin
            $error("penable without a preceding setup cycle");
            fail_cnt++;
        end

    a_wdt_pulse_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        wdt_reset_i |-> bite_len_q < soc_periph_pkg::WDT_RST_CYCLES)
        else begin
            $error("watchdog reset pulse too long");
            fail_cnt++;
        end

    a_wdt_pulse_len: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        $fell(wdt_reset_i) |-> bite_len_q == soc_periph_pkg::WDT_RST_CYCLES)
        else begin
            $error("watchdog reset pulse too short");
            fail_cnt++;
        end

endmodule

bind soc_periph_lite soc_periph_lite_sva u_sva (
    .clk_i       ( clk_i       ),
    .arst_n_i    ( arst_n_i    ),
    .psel_i      ( psel_i      ),
    .penable_i   ( penable_i   ),
    .pready_i    ( pready_o    ),
    .pslverr_i   ( pslverr_o   ),
    .wdt_reset_i ( wdt_reset_o )
);

// File: verif/tb_soc_periph_lite.sv
/*
 * directed testbench for the soc_periph_lite subsystem
 * drives the APB port and the pins and checks the responses
 */
`timescale 1ns/1ns

module tb_soc_periph_lite;

    localparam int TIMEOUT_CYCLES = 5000;

    logic        clk;
    logic        arst_n;
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [31:0] gpio_in;
    logic [31:0] gpio_out;
    logic [31:0] gpio_dir;
    logic        dma_pe_evt;
    logic        dma_pe_irq;
    logic        pf_evt;
    logic [31:0] fc_events;
    logic        wdt_reset;
    integer      seed;
    int unsigned cycle_cnt = 0;

    soc_periph_lite DUT (
        .clk_i        ( clk        ),
        .arst_n_i     ( arst_n     ),
        .paddr_i      ( paddr      ),
        .psel_i       ( psel       ),
        .penable_i    ( penable    ),
        .pwrite_i     ( pwrite     ),
        .pwdata_i     ( pwdata     ),
        .prdata_o     ( prdata     ),
        .pready_o     ( pready     ),
        .pslverr_o    ( pslverr    ),
        .gpio_in_i    ( gpio_in    ),
        .gpio_out_o   ( gpio_out   ),
        .gpio_dir_o   ( gpio_dir   ),
        .dma_pe_evt_i ( dma_pe_evt ),
        .dma_pe_irq_i ( dma_pe_irq ),
        .pf_evt_i     ( pf_evt     ),
        .fc_events_o  ( fc_events  ),
        .wdt_reset_o  ( wdt_reset  )
    );

    always #4 clk = ~clk;

    // cycle count for interval checks and the timeout
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "run stopped by the timeout");
        end
    end

    task automatic report_failure(input string msg);
        $display("Fail at %0t ns: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1, "stopping at the first error");
    endtask

    // window code in paddr[15:12] with the register offset below it
    function automatic logic [31:0] reg_addr(input logic [3:0] win, input logic [11:0] offset);
        return {16'h0000, win, offset};
    endfunction

    ////////////////////
    // apb transfers
    ////////////////////
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b1;
        pwdata  <= data;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        assert (pready === 1'b1) else report_failure($sformatf("no pready on write to %h", addr));
        err = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= 1'b0;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        assert (pready === 1'b1) else report_failure($sformatf("no pready on read of %h", addr));
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_ok(input logic [31:0] addr, input logic [31:0] data);
        logic err;
        apb_write(addr, data, err);
        assert (!err) else report_failure($sformatf("unexpected pslverr on write to %h", addr));
    endtask

    task automatic read_ok(input logic [31:0] addr, output logic [31:0] data);
        logic err;
        apb_read(addr, data, err);
        assert (!err) else report_failure($sformatf("unexpected pslverr on read of %h", addr));
    endtask

    // returns at the first falling edge where the event bit is high
    task automatic wait_for_event(input int idx, input int limit, input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!fc_events[idx]) begin
            assert (waited < limit)
                else report_failure($sformatf("%s not seen within %0d cycles", what, limit));
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic check_reset_state();
        @(negedge clk);
        assert (pready === 1'b0 && pslverr === 1'b0 && wdt_reset === 1'b0)
            else report_failure("bus or watchdog outputs active after reset");
        assert (gpio_out === '0 && gpio_dir === '0 && fc_events === '0)
            else report_failure("gpio or event outputs not zero after reset");
    endtask

    ////////////////////
    // tests
    ////////////////////
    task automatic unmapped_access_test();
        logic [31:0] data;
        logic        err;
        logic [31:0] bad_addr [$];
        for (int w = 0; w < 16; w++) begin
            if (w == 0 || w > 3) bad_addr.push_back(reg_addr(4'(w), 12'h000));
        end
        // unknown offsets inside each mapped window
        bad_addr.push_back(reg_addr(soc_periph_pkg::WIN_GPIO, 12'h014));
        bad_addr.push_back(reg_addr(soc_periph_pkg::WIN_TIMER, 12'h00C));
        bad_addr.push_back(reg_addr(soc_periph_pkg::WIN_WDT, 12'h010));
        foreach (bad_addr[i]) begin
            apb_write(bad_addr[i], $random(seed), err);
            assert (err) else report_failure($sformatf("no pslverr on write to %h", bad_addr[i]));
            apb_read(bad_addr[i], data, err);
            assert (err && data == '0)
                else report_failure($sformatf("read of %h gave err %b data %h",
                                              bad_addr[i], err, data));
        end
        // read-only registers
        apb_write(reg_addr(soc_periph_pkg::WIN_GPIO, soc_periph_pkg::GPIO_IN), 32'hFFFF_FFFF, err);
        assert (err) else report_failure("write to GPIO_IN accepted");
        apb_write(reg_addr(soc_periph_pkg::WIN_WDT, soc_periph_pkg::WDT_STATUS), 32'h1, err);
        assert (err) else report_failure("write to WDT_STATUS accepted");
    endtask

    task automatic gpio_test();
        logic [31:0] dir;
        logic [31:0] out;
        logic [31:0] pins;
        logic [31:0] data;
        int          pin;
        int          polls;
        dir = $random(seed);
        out = $random(seed);
        write_ok(reg_addr(soc_periph_pkg::WIN_GPIO, soc_periph_pkg::GPIO_DIR), dir);
        write_ok(reg_addr(soc_periph_pkg::WIN_GPIO, soc_periph_pkg::GPIO_OUT), out);
        @(negedge clk);
        assert (gpio_dir == dir && gpio_out == out)
            else report_failure($sformatf("gpio_dir %h gpio_out %h, expected %h %h",
                                          gpio_dir, gpio_out, dir, out));
        // inputs pass a two-flop synchroniser
        pins = $random(seed);
        @(posedge clk);
        gpio_in <= pins;
        polls = 0;
        data  = ~pins;
        while (data !== pins) begin
            assert (polls < 8) else report_failure("GPIO_IN never matched the driven pins");
            read_ok(reg_addr(soc_periph_pkg::WIN_GPIO, soc_periph_pkg::GPIO_IN), data);
            polls++;
        end
        // rising edge on one enabled pin
        pin = $random(seed) & 31;
        @(posedge clk);
        gpio_in[pin] <= 1'b0;
        repeat (4) @(posedge clk);
        write_ok(reg_addr(soc_periph_pkg::WIN_GPIO, soc_periph_pkg::GPIO_IRQ_EN), 32'h1 << pin);
        @(posedge clk);
        gpio_in[pin] <= 1'b1;
        wait_for_event(soc_periph_pkg::EVT_GPIO, 8, "GPIO edge event");
        read_ok(reg_addr(soc_periph_pkg::WIN_GPIO, soc_periph_pkg::GPIO_IRQ_STATUS), data);
        assert (data == (32'h1 << pin))
            else report_failure($sformatf("IRQ_STATUS %h, expected pin %0d", data, pin));
        @(negedge clk);
        assert (!fc_events[soc_periph_pkg::EVT_GPIO])
            else report_failure("GPIO event still high after status read");
        write_ok(reg_addr(soc_periph_pkg::WIN_GPIO, soc_periph_pkg::GPIO_IRQ_EN), 32'h0);
    endtask

    task automatic timer_test();
        logic [31:0] n;
        logic [31:0] cnt_a;
        logic [31:0] cnt_b;
        int unsigned t_prev;
        n = 2 + ($random(seed) & 7);
        write_ok(reg_addr(soc_periph_pkg::WIN_TIMER, soc_periph_pkg::TIMER_CMP), n);
        write_ok(reg_addr(soc_periph_pkg::WIN_TIMER, soc_periph_pkg::TIMER_CNT), 32'h0);
        // enable plus clear-on-match
        write_ok(reg_addr(soc_periph_pkg::WIN_TIMER, soc_periph_pkg::TIMER_CFG), 32'h3);
        wait_for_event(soc_periph_pkg::EVT_TIMER, n + 4, "timer match event");
        t_prev = cycle_cnt;
        repeat (3) begin
            @(negedge clk);
            assert (!fc_events[soc_periph_pkg::EVT_TIMER])
                else report_failure("timer event longer than one cycle");
            wait_for_event(soc_periph_pkg::EVT_TIMER, n + 4, "timer match event");
            assert (cycle_cnt - t_prev == n + 1)
                else report_failure($sformatf("match pulses %0d cycles apart, expected %0d",
                                              cycle_cnt - t_prev, n + 1));
            t_prev = cycle_cnt;
        end
        write_ok(reg_addr(soc_periph_pkg::WIN_TIMER, soc_periph_pkg::TIMER_CFG), 32'h0);
        read_ok(reg_addr(soc_periph_pkg::WIN_TIMER, soc_periph_pkg::TIMER_CNT), cnt_a);
        read_ok(reg_addr(soc_periph_pkg::WIN_TIMER, soc_periph_pkg::TIMER_CNT), cnt_b);
        assert (cnt_a == cnt_b)
            else report_failure($sformatf("stopped counter moved from %0d to %0d", cnt_a, cnt_b));
    endtask

    task automatic watchdog_test();
        logic [31:0] load;
        logic [31:0] data;
        int unsigned t_kick;
        int          high_cycles;
        load = 20 + ($random(seed) & 15);
        write_ok(reg_addr(soc_periph_pkg::WIN_WDT, soc_periph_pkg::WDT_LOAD), load);
        write_ok(reg_addr(soc_periph_pkg::WIN_WDT, soc_periph_pkg::WDT_CTRL), 32'h1);
        repeat (6) begin
            repeat (4) begin
                @(negedge clk);
                assert (!wdt_reset) else report_failure("watchdog fired while being kicked");
            end
            write_ok(reg_addr(soc_periph_pkg::WIN_WDT, soc_periph_pkg::WDT_KICK),
                     soc_periph_pkg::WDT_KICK_KEY);
        end
        @(negedge clk);
        t_kick = cycle_cnt;
        repeat (load / 2) begin
            assert (!wdt_reset) else report_failure("watchdog fired too early");
            @(negedge clk);
        end
        // a wrong key leaves the countdown running
        write_ok(reg_addr(soc_periph_pkg::WIN_WDT, soc_periph_pkg::WDT_KICK),
                 soc_periph_pkg::WDT_KICK_KEY ^ 32'h1);
        @(negedge clk);
        while (!wdt_reset) begin
            assert (cycle_cnt - t_kick <= load + 4)
                else report_failure("watchdog reset did not rise within L+4 cycles");
            @(negedge clk);
        end
        high_cycles = 0;
        while (wdt_reset) begin
            high_cycles++;
            @(negedge clk);
        end
        assert (high_cycles == soc_periph_pkg::WDT_RST_CYCLES)
            else report_failure($sformatf("reset pulse lasted %0d cycles", high_cycles));
        read_ok(reg_addr(soc_periph_pkg::WIN_WDT, soc_periph_pkg::WDT_STATUS), data);
        assert (data[1:0] == soc_periph_pkg::WDT_OFF && data[2] == 1'b0)
            else report_failure($sformatf("STATUS %h after the bite", data));
    endtask

    task automatic event_map_test();
        logic [2:0]  bits;
        logic [31:0] expected;
        repeat (16) begin
            bits = 3'($random(seed));
            @(posedge clk);
            dma_pe_evt <= bits[0];
            dma_pe_irq <= bits[1];
            pf_evt     <= bits[2];
            @(negedge clk);
            expected = '0;
            expected[soc_periph_pkg::EVT_DMA_PE]  = bits[0];
            expected[soc_periph_pkg::EVT_DMA_IRQ] = bits[1];
            expected[soc_periph_pkg::EVT_PF]      = bits[2];
            assert (fc_events === expected)
                else report_failure($sformatf("fc_events_o %h, expected %h", fc_events, expected));
        end
        @(posedge clk);
        dma_pe_evt <= 1'b0;
        dma_pe_irq <= 1'b0;
        pf_evt     <= 1'b0;
    endtask

    initial begin
        seed       = 32'hc48a_bbda;
        clk        = 1'b0;
        arst_n     = 1'b0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        gpio_in    = '0;
        dma_pe_evt = 1'b0;
        dma_pe_irq = 1'b0;
        pf_evt     = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        check_reset_state();
        unmapped_access_test();
        gpio_test();
        timer_test();
        watchdog_test();
        event_map_test();
        repeat (2) @(posedge clk);
        if (DUT.u_sva.fail_cnt != 0) begin
            $display("Bound assertions failed %0d times during the run", DUT.u_sva.fail_cnt);
            $display("Testbench failed");
            $fatal(1, "stopping after assertion failures");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule
